//--- common/csr_pkg.sv
package csr_pkg;

   //**********************************************************
   // address space
   //**********************************************************

   parameter int unsigned csr_addr_width = 12;

   typedef logic [csr_addr_width-1:0] csr_addr_t;

   // machine trap setup
   parameter csr_addr_t csr_mstatus_addr       = 12'h300;
   parameter csr_addr_t csr_misa_addr          = 12'h301;
   parameter csr_addr_t csr_mie_addr           = 12'h304;
   parameter csr_addr_t csr_mtvec_addr         = 12'h305;
   parameter csr_addr_t csr_mcountinhibit_addr = 12'h320;

   // machine trap handling
   parameter csr_addr_t csr_mscratch_addr      = 12'h340;
   parameter csr_addr_t csr_mepc_addr          = 12'h341;
   parameter csr_addr_t csr_mcause_addr        = 12'h342;
   parameter csr_addr_t csr_mtval_addr         = 12'h343;
   parameter csr_addr_t csr_mip_addr           = 12'h344;

   // trigger module
   parameter csr_addr_t csr_tselect_addr       = 12'h7a0;
   parameter csr_addr_t csr_tdata1_addr        = 12'h7a1;
   parameter csr_addr_t csr_tdata2_addr        = 12'h7a2;

   // debug mode only
   parameter csr_addr_t csr_dcsr_addr          = 12'h7b0;
   parameter csr_addr_t csr_dpc_addr           = 12'h7b1;

   // internal timers, two instances
   parameter csr_addr_t csr_mitcnt0_addr       = 12'h7d2;
   parameter csr_addr_t csr_mitb0_addr         = 12'h7d3;
   parameter csr_addr_t csr_mitctl0_addr       = 12'h7d4;
   parameter csr_addr_t csr_mitcnt1_addr       = 12'h7d5;
   parameter csr_addr_t csr_mitb1_addr         = 12'h7d6;
   parameter csr_addr_t csr_mitctl1_addr       = 12'h7d7;

   // machine counters, low and high halves
   parameter csr_addr_t csr_mcycle_addr        = 12'hb00;
   parameter csr_addr_t csr_minstret_addr      = 12'hb02;
   parameter csr_addr_t csr_mcycleh_addr       = 12'hb80;
   parameter csr_addr_t csr_minstreth_addr     = 12'hb82;

   // machine information, read only
   parameter csr_addr_t csr_mvendorid_addr     = 12'hf11;
   parameter csr_addr_t csr_marchid_addr       = 12'hf12;
   parameter csr_addr_t csr_mimpid_addr        = 12'hf13;
   parameter csr_addr_t csr_mhartid_addr       = 12'hf14;

   //**********************************************************
   // decode results
   //**********************************************************

   // one bit per csr, one hot or all zero
   typedef struct packed {
      logic mstatus;
      logic misa;
      logic mie;
      logic mtvec;
      logic mcountinhibit;
      logic mscratch;
      logic mepc;
      logic mcause;
      logic mtval;
      logic mip;
      logic tselect;
      logic tdata1;
      logic tdata2;
      logic dcsr;
      logic dpc;
      logic mitcnt0;
      logic mitb0;
      logic mitctl0;
      logic mitcnt1;
      logic mitb1;
      logic mitctl1;
      logic mcycle;
      logic minstret;
      logic mcycleh;
      logic minstreth;
      logic mvendorid;
      logic marchid;
      logic mimpid;
      logic mhartid;
   } csr_sel_t;

   typedef struct packed {
      logic known;
      logic read_only;
      logic debug_only;
      logic timer;
      logic presync;
      logic postsync;
   } csr_attr_t;

   //**********************************************************
   // request and response
   //**********************************************************

   typedef struct packed {
      csr_addr_t addr;
      logic      any;
      logic      wen;
   } csr_req_t;

   typedef struct packed {
      logic     valid;
      logic     legal;
      logic     presync;
      logic     postsync;
      csr_sel_t sel;
   } csr_rsp_t;

endpackage

//--- csr_decode/csr_addr_decode.sv
`timescale 1ns/100ps

module csr_addr_decode (
   input  csr_pkg::csr_addr_t addr,
   output csr_pkg::csr_sel_t  sel,
   output csr_pkg::csr_attr_t attr
);
   import csr_pkg::*;

   //**********************************************************
   // one-hot select
   //**********************************************************

   // full 12-bit compare, so aliases never hit
   always_comb begin
      sel = '0;

      sel.mstatus       = (addr == csr_mstatus_addr);
      sel.misa          = (addr == csr_misa_addr);
      sel.mie           = (addr == csr_mie_addr);
      sel.mtvec         = (addr == csr_mtvec_addr);
      sel.mcountinhibit = (addr == csr_mcountinhibit_addr);

      sel.mscratch      = (addr == csr_mscratch_addr);
      sel.mepc          = (addr == csr_mepc_addr);
      sel.mcause        = (addr == csr_mcause_addr);
      sel.mtval         = (addr == csr_mtval_addr);
      sel.mip           = (addr == csr_mip_addr);

      sel.tselect       = (addr == csr_tselect_addr);
      sel.tdata1        = (addr == csr_tdata1_addr);
      sel.tdata2        = (addr == csr_tdata2_addr);

      sel.dcsr          = (addr == csr_dcsr_addr);
      sel.dpc           = (addr == csr_dpc_addr);

      sel.mitcnt0       = (addr == csr_mitcnt0_addr);
      sel.mitb0         = (addr == csr_mitb0_addr);
      sel.mitctl0       = (addr == csr_mitctl0_addr);
      sel.mitcnt1       = (addr == csr_mitcnt1_addr);
      sel.mitb1         = (addr == csr_mitb1_addr);
      sel.mitctl1       = (addr == csr_mitctl1_addr);

      sel.mcycle        = (addr == csr_mcycle_addr);
      sel.minstret      = (addr == csr_minstret_addr);
      sel.mcycleh       = (addr == csr_mcycleh_addr);
      sel.minstreth     = (addr == csr_minstreth_addr);

      sel.mvendorid     = (addr == csr_mvendorid_addr);
      sel.marchid       = (addr == csr_marchid_addr);
      sel.mimpid        = (addr == csr_mimpid_addr);
      sel.mhartid       = (addr == csr_mhartid_addr);
   end

   //**********************************************************
   // attribute classes
   //**********************************************************

   // every class is an OR of select bits, unknown address gives all zeros
   assign attr.known = |sel;

   assign attr.read_only = sel.mvendorid |
                           sel.marchid   |
                           sel.mimpid    |
                           sel.mhartid;

   assign attr.debug_only = sel.dcsr | sel.dpc;

   assign attr.timer = sel.mitcnt0 |
                       sel.mitb0   |
                       sel.mitctl0 |
                       sel.mitcnt1 |
                       sel.mitb1   |
                       sel.mitctl1;

   // counter reads must see all older instructions retired
   assign attr.presync = sel.mcycle        |
                         sel.mcycleh       |
                         sel.minstret      |
                         sel.minstreth     |
                         sel.mcountinhibit;

   // these change fetch, trap or trigger behavior of younger instructions
   assign attr.postsync = sel.mstatus       |
                          sel.mtvec         |
                          sel.mepc          |
                          sel.mcountinhibit |
                          sel.tdata1        |
                          sel.tdata2        |
                          sel.dcsr;

endmodule

//--- csr_decode/csr_access_check.sv
`timescale 1ns/100ps

module csr_access_check #(
   parameter bit timer_legal_en = 1'b1
) (
   input  logic               clk,
   input  logic               rst,
   input  csr_pkg::csr_req_t  req,
   input  logic               dbg_halted,
   input  csr_pkg::csr_sel_t  sel,
   input  csr_pkg::csr_attr_t attr,
   output csr_pkg::csr_rsp_t  rsp
);
   import csr_pkg::*;

   logic     debug_ok;
   logic     timer_ok;
   logic     ro_write;
   logic     legal_d;
   logic     presync_d;
   logic     postsync_d;
   csr_sel_t sel_d;

   //**********************************************************
   // legality
   //**********************************************************

   // dcsr and dpc only while the hart sits in debug mode
   assign debug_ok = ~attr.debug_only | dbg_halted;

   assign timer_ok = ~attr.timer | timer_legal_en;

   assign ro_write = req.wen & attr.read_only;

   assign legal_d = req.any    &
                    attr.known &
                    debug_ok   &
                    timer_ok   &
                    ~ro_write;

   //**********************************************************
   // sync requests
   //**********************************************************

   // only reads of the counters wait for the pipe to drain
   assign presync_d = req.any & ~req.wen & attr.presync;

   assign postsync_d = req.any & attr.postsync;

   // no select without a request
   assign sel_d = req.any ? sel : '0;

   //**********************************************************
   // output register
   //**********************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp <= '0;
      end else begin
         rsp.valid    <= req.any;
         rsp.legal    <= legal_d;
         rsp.presync  <= presync_d;
         rsp.postsync <= postsync_d;
         rsp.sel      <= sel_d;
      end
   end

endmodule

//--- hw/csr_decode_top.sv
`timescale 1ns/100ps

module csr_decode_top #(
   parameter bit timer_legal_en = 1'b1
) (
   input  logic              clk,
   input  logic              rst,
   input  csr_pkg::csr_req_t csr_req,
   input  logic              dbg_halted,
   output csr_pkg::csr_rsp_t csr_rsp
);
   import csr_pkg::*;

   csr_sel_t  sel;
   csr_attr_t attr;

   //**********************************************************
   // address decode, combinational
   //**********************************************************

   csr_addr_decode csr_addr_decode_inst (
      .addr (csr_req.addr),
      .sel  (sel),
      .attr (attr)
   );

   //**********************************************************
   // legality check and response register
   //**********************************************************

   csr_access_check #(
      .timer_legal_en (timer_legal_en)
   ) csr_access_check_inst (
      .clk        (clk),
      .rst        (rst),
      .req        (csr_req),
      .dbg_halted (dbg_halted),
      .sel        (sel),
      .attr       (attr),
      .rsp        (csr_rsp)
   );

endmodule

//--- test/csr_decode_tasks.svh
`ifndef csr_decode_tasks_svh
`define csr_decode_tasks_svh

// one request followed by a wait for its response and a compare with the model
task automatic access(input csr_addr_t addr, input logic wen, input logic halted,
                      input string label);
   csr_req_t req;
   csr_rsp_t exp;
   int       cycles;
   bit       seen;
   req.addr = addr;
   req.any  = 1'b1;
   req.wen  = wen;
   exp      = expect_rsp(req, halted);
   @(posedge clk);
   #2;
   csr_req    = req;
   dbg_halted = halted;
   cycles     = 0;
   seen       = 1'b0;
   while (!seen && cycles < rsp_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
      seen = (csr_rsp.valid === 1'b1);
   end
   if (!seen) begin
      timeout_errors++;
      $display("timeout: no valid response to %s within %0d cycles", label, rsp_timeout);
   end else begin
      if (cycles != 1) report_mismatch(label, "latency", cycles, 1);
      compare_rsp(exp, label);
   end
   #1;
   csr_req.any = 1'b0;
endtask

// address on the bus without the strobe leaves the response all zero
task automatic idle_cycle(input csr_addr_t addr, input logic wen);
   @(posedge clk);
   #2;
   csr_req.addr = addr;
   csr_req.any  = 1'b0;
   csr_req.wen  = wen;
   @(posedge clk);
   #1;
   if (csr_rsp !== '0) report_mismatch("idle", "rsp", csr_rsp, 0);
   #1;
endtask

task automatic test_reset_idle();
   if (csr_rsp !== '0) report_mismatch("after reset", "rsp", csr_rsp, 0);
   idle_cycle(csr_mstatus_addr, 1'b0);
   idle_cycle(csr_mcycle_addr, 1'b1);
   idle_cycle(csr_dcsr_addr, 1'b0);
endtask

task automatic test_read_known();
   for (int i = 0; i < num_known; i++) begin
      access(known_addrs[i], 1'b0, 1'b0, $sformatf("read %h", known_addrs[i]));
      if ($countones(csr_rsp.sel) != 1) begin
         report_mismatch("one-hot sel", "bits set", $countones(csr_rsp.sel), 1);
      end
   end
endtask

task automatic test_read_only_and_unknown();
   csr_addr_t   addr;
   int unsigned draw;
   for (int i = 25; i < num_known; i++) begin
      access(known_addrs[i], 1'b1, 1'b0, $sformatf("write ro %h", known_addrs[i]));
      if (csr_rsp.legal !== 1'b0) report_mismatch("ro write", "legal", csr_rsp.legal, 0);
      access(known_addrs[i], 1'b0, 1'b0, $sformatf("read ro %h", known_addrs[i]));
      if (csr_rsp.legal !== 1'b1) report_mismatch("ro read", "legal", csr_rsp.legal, 1);
   end
   for (int i = 0; i < 30; i++) begin
      do begin
         draw = $urandom;
         addr = draw[csr_addr_width-1:0];
      end while (is_known(addr));
      access(addr, draw[12], draw[13], $sformatf("unknown %h", addr));
      if (csr_rsp.legal !== 1'b0) report_mismatch("unknown", "legal", csr_rsp.legal, 0);
      if (csr_rsp.sel !== '0) report_mismatch("unknown", "sel", csr_rsp.sel, 0);
   end
endtask

task automatic test_debug_and_timer();
   for (int w = 0; w < 2; w++) begin
      access(csr_dcsr_addr, w[0], 1'b1, "dcsr halted");
      if (csr_rsp.legal !== 1'b1) report_mismatch("dcsr halted", "legal", csr_rsp.legal, 1);
      access(csr_dpc_addr, w[0], 1'b1, "dpc halted");
      if (csr_rsp.legal !== 1'b1) report_mismatch("dpc halted", "legal", csr_rsp.legal, 1);
      for (int i = 15; i < 21; i++) begin
         access(known_addrs[i], w[0], 1'b0, $sformatf("timer %h", known_addrs[i]));
         if (csr_rsp.legal !== 1'b1) report_mismatch("timer", "legal", csr_rsp.legal, 1);
      end
   end
endtask

task automatic test_sync_attrs();
   csr_addr_t pre_addrs [5];
   csr_addr_t post_addrs [7];
   pre_addrs  = '{csr_mcycle_addr, csr_mcycleh_addr, csr_minstret_addr,
                  csr_minstreth_addr, csr_mcountinhibit_addr};
   post_addrs = '{csr_mstatus_addr, csr_mtvec_addr, csr_mepc_addr, csr_mcountinhibit_addr,
                  csr_tdata1_addr, csr_tdata2_addr, csr_dcsr_addr};
   foreach (pre_addrs[i]) begin
      access(pre_addrs[i], 1'b0, 1'b0, $sformatf("presync read %h", pre_addrs[i]));
      if (csr_rsp.presync !== 1'b1) report_mismatch("read", "presync", csr_rsp.presync, 1);
      access(pre_addrs[i], 1'b1, 1'b0, $sformatf("presync write %h", pre_addrs[i]));
      if (csr_rsp.presync !== 1'b0) report_mismatch("write", "presync", csr_rsp.presync, 0);
   end
   foreach (post_addrs[i]) begin
      for (int w = 0; w < 2; w++) begin
         access(post_addrs[i], w[0], 1'b1, $sformatf("postsync %h wen %0d", post_addrs[i], w));
         if (csr_rsp.postsync !== 1'b1) begin
            report_mismatch("postsync", "postsync", csr_rsp.postsync, 1);
         end
      end
   end
endtask

// a new request every cycle and each response checked one edge later
task automatic test_back_to_back();
   csr_rsp_t    exp;
   csr_req_t    req;
   logic        halted;
   int unsigned draw;
   for (int i = 0; i < 24; i++) begin
      draw     = $urandom;
      req.addr = draw[0] ? known_addrs[draw[15:8] % num_known] : draw[27:16];
      req.any  = (draw[3:1] != 3'd0);
      req.wen  = draw[4];
      halted   = draw[5];
      csr_req    = req;
      dbg_halted = halted;
      exp        = expect_rsp(req, halted);
      @(posedge clk);
      #1;
      compare_rsp(exp, $sformatf("back-to-back %0d addr %h", i, req.addr));
      #1;
   end
   csr_req.any = 1'b0;
endtask

`endif

//--- test/csr_decode_tb.sv
`timescale 1ns/100ps

module csr_decode_tb;
   import csr_pkg::*;

   localparam bit timer_legal_en = 1'b1;
   localparam int rsp_timeout    = 8;
   localparam int num_known      = 29;

   logic     clk;
   logic     rst;
   csr_req_t csr_req;
   logic     dbg_halted;
   csr_rsp_t csr_rsp;

   int value_errors;
   int timeout_errors;

   csr_addr_t known_addrs [num_known] = '{
      csr_mstatus_addr, csr_misa_addr, csr_mie_addr, csr_mtvec_addr,
      csr_mcountinhibit_addr, csr_mscratch_addr, csr_mepc_addr, csr_mcause_addr,
      csr_mtval_addr, csr_mip_addr, csr_tselect_addr, csr_tdata1_addr,
      csr_tdata2_addr, csr_dcsr_addr, csr_dpc_addr, csr_mitcnt0_addr,
      csr_mitb0_addr, csr_mitctl0_addr, csr_mitcnt1_addr, csr_mitb1_addr,
      csr_mitctl1_addr, csr_mcycle_addr, csr_minstret_addr, csr_mcycleh_addr,
      csr_minstreth_addr, csr_mvendorid_addr, csr_marchid_addr, csr_mimpid_addr,
      csr_mhartid_addr
   };

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   csr_decode_top #(
      .timer_legal_en (timer_legal_en)
   ) csr_decode_top_inst (
      .clk        (clk),
      .rst        (rst),
      .csr_req    (csr_req),
      .dbg_halted (dbg_halted),
      .csr_rsp    (csr_rsp)
   );

   //**********************************************************
   // reference model
   //**********************************************************

   function automatic csr_rsp_t expect_rsp(input csr_req_t req, input logic halted);
      csr_sel_t s;
      csr_rsp_t r;
      logic     ro;
      logic     dbg_only;
      logic     tmr;
      logic     pre;
      logic     post;
      s = '0;
      case (req.addr)
         csr_mstatus_addr:       s.mstatus = 1'b1;
         csr_misa_addr:          s.misa = 1'b1;
         csr_mie_addr:           s.mie = 1'b1;
         csr_mtvec_addr:         s.mtvec = 1'b1;
         csr_mcountinhibit_addr: s.mcountinhibit = 1'b1;
         csr_mscratch_addr:      s.mscratch = 1'b1;
         csr_mepc_addr:          s.mepc = 1'b1;
         csr_mcause_addr:        s.mcause = 1'b1;
         csr_mtval_addr:         s.mtval = 1'b1;
         csr_mip_addr:           s.mip = 1'b1;
         csr_tselect_addr:       s.tselect = 1'b1;
         csr_tdata1_addr:        s.tdata1 = 1'b1;
         csr_tdata2_addr:        s.tdata2 = 1'b1;
         csr_dcsr_addr:          s.dcsr = 1'b1;
         csr_dpc_addr:           s.dpc = 1'b1;
         csr_mitcnt0_addr:       s.mitcnt0 = 1'b1;
         csr_mitb0_addr:         s.mitb0 = 1'b1;
         csr_mitctl0_addr:       s.mitctl0 = 1'b1;
         csr_mitcnt1_addr:       s.mitcnt1 = 1'b1;
         csr_mitb1_addr:         s.mitb1 = 1'b1;
         csr_mitctl1_addr:       s.mitctl1 = 1'b1;
         csr_mcycle_addr:        s.mcycle = 1'b1;
         csr_minstret_addr:      s.minstret = 1'b1;
         csr_mcycleh_addr:       s.mcycleh = 1'b1;
         csr_minstreth_addr:     s.minstreth = 1'b1;
         csr_mvendorid_addr:     s.mvendorid = 1'b1;
         csr_marchid_addr:       s.marchid = 1'b1;
         csr_mimpid_addr:        s.mimpid = 1'b1;
         csr_mhartid_addr:       s.mhartid = 1'b1;
         default:                s = '0;
      endcase
      ro       = (req.addr[11:4] == 8'hf1) && (req.addr[3:0] >= 4'h1) &&
                 (req.addr[3:0] <= 4'h4);
      dbg_only = (req.addr == csr_dcsr_addr) || (req.addr == csr_dpc_addr);
      tmr      = (req.addr >= csr_mitcnt0_addr) && (req.addr <= csr_mitctl1_addr);
      case (req.addr)
         csr_mcycle_addr, csr_mcycleh_addr, csr_minstret_addr, csr_minstreth_addr,
         csr_mcountinhibit_addr: pre = 1'b1;
         default:                pre = 1'b0;
      endcase
      case (req.addr)
         csr_mstatus_addr, csr_mtvec_addr, csr_mepc_addr, csr_mcountinhibit_addr,
         csr_tdata1_addr, csr_tdata2_addr, csr_dcsr_addr: post = 1'b1;
         default:                                         post = 1'b0;
      endcase
      r.valid    = req.any;
      r.legal    = req.any && (s != '0) && (!dbg_only || halted) &&
                   (!tmr || timer_legal_en) && !(req.wen && ro);
      r.presync  = req.any && !req.wen && pre;
      r.postsync = req.any && post;
      r.sel      = req.any ? s : '0;
      return r;
   endfunction

   function automatic bit is_known(input csr_addr_t addr);
      for (int i = 0; i < num_known; i++) begin
         if (known_addrs[i] == addr) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   //**********************************************************
   // checking and report
   //**********************************************************

   task automatic report_mismatch(input string label, input string field,
                                  input logic [63:0] got, input logic [63:0] exp);
      value_errors++;
      $display("[ERROR] %0d ns: %s, %s is %0h, expected %0h", $time, label, field, got, exp);
   endtask

   task automatic compare_rsp(input csr_rsp_t exp, input string label);
      if (csr_rsp.valid !== exp.valid) report_mismatch(label, "valid", csr_rsp.valid, exp.valid);
      if (csr_rsp.legal !== exp.legal) report_mismatch(label, "legal", csr_rsp.legal, exp.legal);
      if (csr_rsp.presync !== exp.presync) begin
         report_mismatch(label, "presync", csr_rsp.presync, exp.presync);
      end
      if (csr_rsp.postsync !== exp.postsync) begin
         report_mismatch(label, "postsync", csr_rsp.postsync, exp.postsync);
      end
      if (csr_rsp.sel !== exp.sel) report_mismatch(label, "sel", csr_rsp.sel, exp.sel);
   endtask

   task automatic finish_run();
      $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   `include "csr_decode_tasks.svh"

   initial begin
      value_errors   = 0;
      timeout_errors = 0;
      void'($urandom(1));
      rst            = 1'b1;
      dbg_halted     = 1'b0;
      // a live legal read during reset must not reach the response
      csr_req        = '0;
      csr_req.addr   = csr_mstatus_addr;
      csr_req.any    = 1'b1;
      repeat (5) @(posedge clk);
      #2;
      rst     = 1'b0;
      csr_req = '0;

      test_reset_idle();
      test_read_known();
      test_read_only_and_unknown();
      test_debug_and_timer();
      test_sync_attrs();
      test_back_to_back();

      finish_run();
   end

endmodule

//--- project.f
+incdir+test
common/csr_pkg.sv
csr_decode/csr_addr_decode.sv
csr_decode/csr_access_check.sv
hw/csr_decode_top.sv
test/csr_decode_tb.sv

//--- Bender.yml
package:
  name: csr_decode

sources:
  # package first, then the decode block and the top level
  - files:
      - common/csr_pkg.sv
      - csr_decode/csr_addr_decode.sv
      - csr_decode/csr_access_check.sv
      - hw/csr_decode_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/csr_decode_tb.sv
